/* Makefile */
# Verilator build for the RV32I pipeline controller testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= controllerTb
FILELIST  ?= controller.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* controller.f */
+incdir+source
source/controllerPkg.sv
source/instrDecoder.sv
source/stageReg.sv
source/executeCtrl.sv
source/controller.sv
sim/clockGen.sv
sim/controller_asserts.sv
sim/controllerTb.sv

/* sim/clockGen.sv */
//////////////////////////////
// Clock and reset source for the controller testbench
// Reset is held low for a fixed number of cycles, released on a falling edge
//////////////////////////////

`timescale 1ns/100ps

module clockGen #(
  parameter int periodNs    = 100,   // Clock period
  parameter int resetCycles = 16     // Cycles with rstN low
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;                     // Away from the sampling edge
  end

endmodule

/* sim/controllerTb.sv */
//////////////////////////////
// Testbench for the RV32I pipeline controller
// Stands in for hazard unit and datapath, drives on the falling edge
// A reference decoder and a shadow pipeline give the expected outputs
// A compare process checks every cycle shortly before the rising edge
//////////////////////////////

`timescale 1ns/100ps

`include "controller_params.svh"

module controllerTb;
  import controllerPkg::*;

  localparam int       decodeCount = 400;           // Random decode cycles
  localparam int       stallCount  = 300;           // Random stall and flush cycles
  localparam int       testCount   = decodeCount + stallCount + 100;
  localparam logic [31:0] nopInstr = 32'h00000013;  // addi x0, x0, 0
  localparam stageCtlT noCtl       = '{stall: 1'b0, flush: 1'b0};

  logic        clk, rstN;
  logic [31:0] instrD;
  logic [1:0]  flagsE;                              // {eq, lt}
  stageCtlT    ctlD, ctlE, ctlM, ctlW;
  decodeOutT   decodeD;
  logic        instrValidD, pcSrcE, branchSignedE, memReadE;
  execCtrlT    execE;
  memCtrlT     memM;
  wbCtrlT      wbW;

  logic [31:0] lfsrState;
  string       testName = "reset";
  logic        checkEnable = 1'b0;
  int          errorCount = 0;
  execCtrlT    expExecD, shE;                       // Expected decode, shadow Execute
  decodeOutT   expDecD;
  memCtrlT     expMemE, shM;
  wbCtrlT      shW;
  logic        shValidD;

  clockGen #(.periodNs(100), .resetCycles(16)) i_clockGen (.clk(clk), .rstN(rstN));

  controller i_dut (
    .clk(clk), .rstN(rstN), .instrD(instrD), .flagsE(flagsE),
    .ctlD(ctlD), .ctlE(ctlE), .ctlM(ctlM), .ctlW(ctlW),
    .decodeD(decodeD), .instrValidD(instrValidD), .execE(execE), .pcSrcE(pcSrcE),
    .branchSignedE(branchSignedE), .memReadE(memReadE), .memM(memM), .wbW(wbW)
  );

  ////////////////////////////// Random source

  function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Right-shifting Galois step
  endfunction

  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value     = {value[30:0], lfsrState[0]};
      lfsrState = stepLfsr(lfsrState);                    // One step per bit
    end
    return value;
  endfunction

  function automatic logic [6:0] pickOpcode(input logic [3:0] sel);
    logic [31:0] raw;
    case (sel)
      4'd0:    return opLoad;
      4'd1:    return opMiscMem;
      4'd2:    return opOpImm;
      4'd3:    return opAuipc;
      4'd4:    return opStore;
      4'd5:    return opOp;
      4'd6:    return opLui;
      4'd7:    return opBranch;
      4'd8:    return opJalr;
      4'd9:    return opJal;
      4'd10:   return opSystem;
      default: begin
        raw = takeBits(7);                                // Mostly unknown opcodes
        return raw[6:0];
      end
    endcase
  endfunction

  function automatic logic [31:0] randomInstr();
    logic [31:0] instr;
    logic [3:0]  sel;
    logic [1:0]  bias;
    sel        = 4'(takeBits(4));
    instr      = takeBits(32);
    instr[6:0] = pickOpcode(sel);
    bias       = 2'(takeBits(2));
    if (bias == 2'd0) begin
      instr[31:25] = 7'b0000000;                          // Legal R-type and shift
    end else if (bias == 2'd1) begin
      instr[31:25] = 7'b0100000;                          // sub, sra, srai
    end
    if (takeBits(2) == 32'd0) begin
      instr[19:15] = 5'd0;                                // Zero CSR source
    end
    return instr;
  endfunction

  function automatic stageCtlT randomCtl();
    stageCtlT ctl;
    ctl.stall = (takeBits(2) == 32'd0);
    ctl.flush = (takeBits(2) == 32'd0);
    return ctl;
  endfunction

  ////////////////////////////// Reference model

  function automatic execCtrlT refDecode(input logic [31:0] instr, output decodeOutT dec);
    execCtrlT   e;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       legal, aluOp;
    e     = '0;
    dec   = '0;                                           // immSrc I
    f3    = instr[14:12];
    f7    = instr[31:25];
    legal = 1'b0;
    aluOp = 1'b0;
    case (instr[6:0])
      opLoad: begin
        legal       = (f3 != 3'b011) && (f3 != 3'b110) && (f3 != 3'b111);
        e.regWrite  = 1'b1;
        e.aluSrcB   = 1'b1;
        e.memRw.read = 1'b1;
        e.resultSrc = resLoad;
      end
      opStore: begin
        legal         = (f3 <= 3'b010);
        dec.immSrc    = immS;
        e.aluSrcB     = 1'b1;
        e.memRw.write = 1'b1;
      end
      opOpImm: begin
        if (f3 == 3'b001) legal = (f7 == 7'd0);
        else if (f3 == 3'b101) legal = (f7 == 7'd0) || (f7 == 7'b0100000);
        else legal = 1'b1;
        e.regWrite = 1'b1;
        e.aluSrcB  = 1'b1;
        aluOp      = 1'b1;
      end
      opOp: begin
        legal      = (f7 == 7'd0) || ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
        e.regWrite = 1'b1;
        aluOp      = 1'b1;
      end
      opAuipc: begin
        legal      = 1'b1;
        dec.immSrc = immU;
        e.regWrite = 1'b1;
        e.aluSrcA  = 1'b1;
        e.aluSrcB  = 1'b1;
      end
      opLui: begin
        legal          = 1'b1;
        dec.immSrc     = immU;
        e.regWrite     = 1'b1;
        e.aluSrcB      = 1'b1;
        e.aluResultSrc = 1'b1;
      end
      opBranch: begin
        legal      = (f3 != 3'b010) && (f3 != 3'b011);
        dec.immSrc = immB;
        e.aluSrcA  = 1'b1;
        e.aluSrcB  = 1'b1;
        e.branch   = 1'b1;
      end
      opJalr: begin
        legal          = (f3 == 3'b000);
        e.regWrite     = 1'b1;
        e.aluSrcB      = 1'b1;
        e.jump         = 1'b1;
        e.aluResultSrc = 1'b1;
      end
      opJal: begin
        legal          = 1'b1;
        dec.immSrc     = immJ;
        e.regWrite     = 1'b1;
        e.aluSrcA      = 1'b1;
        e.aluSrcB      = 1'b1;
        e.jump         = 1'b1;
        e.aluResultSrc = 1'b1;
      end
      opMiscMem: begin
        legal   = 1'b1;
        e.fence = `ZIFENCEI_EN;
      end
      opSystem: begin
        legal = `ZICSR_EN;
        if (f3 == 3'b000) begin
          e.privileged = 1'b1;
        end else begin
          e.csrRead   = 1'b1;
          e.resultSrc = resCsr;
        end
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      e          = '0;                                    // Nothing survives an illegal decode
      dec.immSrc = immI;
      aluOp      = 1'b0;
    end
    e.aluSel   = aluOp ? f3 : 3'b000;
    e.subArith = aluOp && (((f3 == 3'b000) && f7[5] && instr[5]) ||
                           ((f3 == 3'b101) && f7[5]) || (f3 == 3'b010) || (f3 == 3'b011));
    e.csrWrite = e.csrRead && !(f3[1] && (instr[19:15] == 5'd0));
    e.invalidateICache = e.fence && (f3 == 3'b001) && `ICACHE_EN;
    e.flushDCache      = e.invalidateICache;
    e.funct3     = f3;
    e.instrValid = 1'b1;
    dec.jump     = e.jump;
    dec.branch   = e.branch;
    dec.illegal  = !legal;
    return e;
  endfunction

  function automatic memCtrlT buildMemPayload(input execCtrlT e);
    memCtrlT m;
    m.regWrite         = e.regWrite;
    m.resultSrc        = e.resultSrc;
    m.memRw            = e.memRw;
    m.csrRead          = e.csrRead;
    m.csrWrite         = e.csrWrite;
    m.privileged       = e.privileged;
    m.funct3           = e.funct3;
    m.invalidateICache = e.invalidateICache;
    m.flushDCache      = e.flushDCache;
    m.csrWriteFence    = e.csrWrite || e.fence;       // Younger work is flushed
    m.instrValid       = e.instrValid;
    return m;
  endfunction

  function automatic logic expectedRedirect(input execCtrlT e, input logic [1:0] flags);
    logic taken;
    case (e.funct3)
      3'b000:  taken = flags[1];                      // beq
      3'b001:  taken = !flags[1];                     // bne
      3'b100,
      3'b110:  taken = flags[0];                      // blt, bltu
      3'b101,
      3'b111:  taken = !flags[0];                     // bge, bgeu
      default: taken = 1'b0;
    endcase
    return e.jump || (e.branch && taken);
  endfunction

  function automatic logic expectedSigned(input execCtrlT e);
    logic unsignedCmp;
    unsignedCmp = (e.funct3 == 3'b110) || (e.funct3 == 3'b111); // bltu, bgeu
    return e.branch && !unsignedCmp;
  endfunction

  always_comb begin : referenceModel
    decodeOutT rawDec;
    expExecD           = refDecode(instrD, rawDec);
    expDecD            = rawDec;
    expDecD.storeStall = shE.memRw.write &&
                         (expExecD.memRw.read || (expExecD.memRw.write && `DCACHE_EN));
    expMemE            = buildMemPayload(shE);
  end

  // A stalled shadow stage holds and ignores flush
  always @(posedge clk or negedge rstN) begin : shadowPipeline
    if (!rstN) begin
      shValidD <= 1'b0;
      shE      <= '0;
      shM      <= '0;
      shW      <= '0;
    end else begin
      if (!ctlD.stall) shValidD <= !ctlD.flush;
      if (!ctlE.stall) shE <= ctlE.flush ? '0 : expExecD;
      if (!ctlM.stall) shM <= ctlM.flush ? '0 : expMemE;
      if (!ctlW.stall) begin
        if (ctlW.flush) begin
          shW <= '0;
        end else begin
          shW.regWrite  <= shM.regWrite;
          shW.resultSrc <= shM.resultSrc;
        end
      end
    end
  end

  ////////////////////////////// Checking

  task automatic stopOnError();
    errorCount++;
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic expectEqual(input string what, input logic [31:0] expVal,
                             input logic [31:0] actVal);
    assert (actVal === expVal) else begin
      $display("mismatch %s %s: expected %h actual %h", testName, what, expVal, actVal);
      stopOnError();
    end
  endtask

  task automatic compareOutputs();
    expectEqual("decodeD", 32'(expDecD), 32'(decodeD));
    expectEqual("instrValidD", 32'(shValidD), 32'(instrValidD));
    expectEqual("execE", 32'(shE), 32'(execE));
    expectEqual("pcSrcE", 32'(expectedRedirect(shE, flagsE)), 32'(pcSrcE));
    expectEqual("branchSignedE", 32'(expectedSigned(shE)), 32'(branchSignedE));
    expectEqual("memReadE", 32'(shE.memRw.read), 32'(memReadE));
    expectEqual("memM", 32'(shM), 32'(memM));
    expectEqual("wbW", 32'(shW), 32'(wbW));
  endtask

  always @(negedge clk) begin : compareProc
    #40;                                              // Just ahead of the rising edge
    if (checkEnable) compareOutputs();
  end

  initial begin : watchdog
    repeat (testCount * 20) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", testCount * 20);
    stopOnError();
  end

  ////////////////////////////// Stimulus

  task automatic applyCycle(input logic [31:0] instr, input logic [1:0] flags,
                            input stageCtlT cD, input stageCtlT cE,
                            input stageCtlT cM, input stageCtlT cW);
    @(negedge clk);
    instrD = instr;
    flagsE = flags;
    ctlD   = cD;
    ctlE   = cE;
    ctlM   = cM;
    ctlW   = cW;
  endtask

  task automatic issue(input logic [31:0] instr, input logic [1:0] flags);
    applyCycle(instr, flags, noCtl, noCtl, noCtl, noCtl);
  endtask

  // Put instr in Execute and resolve it against flags
  task automatic resolveInExecute(input logic [31:0] instr, input logic [1:0] flags);
    issue(instr, 2'b00);
    issue(nopInstr, flags);
  endtask

  task automatic storePairStall(input logic [31:0] older, input logic [31:0] younger,
                                input logic expStall);
    issue(older, 2'b00);
    issue(younger, 2'b00);
    #41;
    expectEqual("storeStall", 32'(expStall), 32'(decodeD.storeStall));
  endtask

  initial begin : stimulus
    logic [31:0] instr;
    logic [1:0]  flags;
    stageCtlT    cD, cE, cM, cW;
    logic [31:0] directed [0:11];
    instrD    = nopInstr;
    flagsE    = 2'b00;
    ctlD      = noCtl;
    ctlE      = noCtl;
    ctlM      = noCtl;
    ctlW      = noCtl;
    lfsrState = 32'd71256;
    directed  = '{32'h0000100F, 32'h0FF0000F, 32'h30011073, 32'h300020F3,
                  32'h3000B073, 32'h00000073, 32'h00012183, 32'h00112023,
                  32'h40208033, 32'h4020D033, 32'h123450B7, 32'h00001097};

    @(posedge rstN);
    #1;
    expectEqual("reset state", 32'h0, 32'({instrValidD, execE.instrValid, memM.instrValid,
                execE.regWrite, memM.regWrite, wbW.regWrite, execE.memRw.write,
                memM.memRw.write, pcSrcE}));
    checkEnable = 1'b1;

    testName = "decode";
    for (int i = 0; i < decodeCount; i++) begin
      instr = randomInstr();
      flags = 2'(takeBits(2));
      issue(instr, flags);
    end

    testName = "propagation";
    for (int i = 0; i < 12; i++) issue(directed[i], 2'b00);
    repeat (3) issue(nopInstr, 2'b00);                // Drain to Writeback

    testName = "stall and flush";
    for (int i = 0; i < stallCount; i++) begin
      instr = randomInstr();
      flags = 2'(takeBits(2));
      cD    = randomCtl();
      cE    = randomCtl();
      cM    = randomCtl();
      cW    = randomCtl();
      applyCycle(instr, flags, cD, cE, cM, cW);
    end

    testName = "branch";
    for (int f = 0; f < 8; f++) begin
      if ((f != 2) && (f != 3)) begin
        for (int fl = 0; fl < 4; fl++) begin
          resolveInExecute({7'b0, 5'd2, 5'd1, 3'(f), 5'd0, opBranch}, 2'(fl));
        end
      end
    end
    for (int fl = 0; fl < 4; fl++) begin
      resolveInExecute(32'h0080006F, 2'(fl));         // jal
      #41;
      expectEqual("jal redirect", 32'd1, 32'(pcSrcE));
      resolveInExecute(32'h00008067, 2'(fl));         // jalr
      #41;
      expectEqual("jalr redirect", 32'd1, 32'(pcSrcE));
    end

    testName = "store stall";
    storePairStall(32'h00112023, 32'h00012183, 1'b1);           // Store then load
    storePairStall(32'h00112023, 32'h00112023, `DCACHE_EN);     // Store then store
    storePairStall(32'h00112023, 32'h002081B3, 1'b0);           // Store then add
    storePairStall(32'h00012183, 32'h00012183, 1'b0);           // Load then load

    repeat (4) issue(nopInstr, 2'b00);
    @(negedge clk);
    #45;
    if (errorCount == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "errors were reported during the run");
    end
  end

endmodule

/* sim/controller_asserts.sv */
//////////////////////////////
// Concurrent checks on the controller outputs
// Bound to every controller instance
//////////////////////////////

`timescale 1ns/100ps

module controllerAsserts (
  input logic                    clk,
  input logic                    rstN,
  input logic                    pcSrcE,
  input logic                    memReadE,
  input controllerPkg::execCtrlT execE,
  input controllerPkg::memCtrlT  memM,
  input controllerPkg::wbCtrlT   wbW,
  input controllerPkg::stageCtlT ctlW
);

  // A redirect needs a jump or a legal branch in Execute
  redirectHasCause: assert property (@(posedge clk) disable iff (!rstN)
    pcSrcE |-> (execE.jump || (execE.branch && (execE.funct3[2:1] != 2'b01))))
    else $error("pcSrcE high without a jump or a legal branch in Execute");

  // One access per instruction
  noReadWithWrite: assert property (@(posedge clk) disable iff (!rstN)
    !(memReadE && execE.memRw.write))
    else $error("memReadE high together with an Execute store");

  // Writeback only carries what Memory held, or what it kept while stalled
  wbWriteFromMemory: assert property (@(posedge clk) disable iff (!rstN)
    wbW.regWrite |-> ($past(memM.regWrite) || $past(ctlW.stall)))
    else $error("wbW.regWrite set without regWrite in the Memory stage before");

endmodule

bind controller controllerAsserts i_asserts (
  .clk      (clk),
  .rstN     (rstN),
  .pcSrcE   (pcSrcE),
  .memReadE (memReadE),
  .execE    (execE),
  .memM     (memM),
  .wbW      (wbW),
  .ctlW     (ctlW)
);

/* source/controller.sv */
//////////////////////////////
// Control unit of the five-stage RV32I pipeline
// Decoder, four stage control registers and Execute logic
// Stall and flush per stage come from the hazard unit
//////////////////////////////

`timescale 1ns/100ps

`include "controller_params.svh"

module controller (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic [`INSTR_W-1:0]       instrD,        // Instruction in Decode
  input  logic [1:0]                flagsE,        // {eq, lt} from comparator
  input  controllerPkg::stageCtlT   ctlD,
  input  controllerPkg::stageCtlT   ctlE,
  input  controllerPkg::stageCtlT   ctlM,
  input  controllerPkg::stageCtlT   ctlW,
  output controllerPkg::decodeOutT  decodeD,
  output logic                      instrValidD,
  output controllerPkg::execCtrlT   execE,
  output logic                      pcSrcE,
  output logic                      branchSignedE,
  output logic                      memReadE,
  output controllerPkg::memCtrlT    memM,
  output controllerPkg::wbCtrlT     wbW
);
  import controllerPkg::*;

  execCtrlT  execD;                              // Decoded payload
  decodeOutT decodeRawD;                         // Decoder side, no stall yet
  memCtrlT   memE;
  wbCtrlT    wbM;                                // Writeback slice of Memory
  logic      storeStallD;

  ////////////////////////////// Decode

  instrDecoder i_decoder (
    .instrD  (instrD),
    .execD   (execD),
    .decodeD (decodeRawD)
  );

  assign decodeD = '{immSrc:     decodeRawD.immSrc,
                     jump:       decodeRawD.jump,
                     branch:     decodeRawD.branch,
                     illegal:    decodeRawD.illegal,
                     storeStall: storeStallD};

  stageReg #(.payloadT(logic)) i_regD (
    .clk(clk), .rstN(rstN), .ctl(ctlD),
    .d(1'b1), .q(instrValidD)                    // Valid once fetch fills Decode
  );

  ////////////////////////////// Execute

  stageReg #(.payloadT(execCtrlT)) i_regE (
    .clk(clk), .rstN(rstN), .ctl(ctlE),
    .d(execD), .q(execE)
  );

  executeCtrl i_execCtrl (
    .execE         (execE),
    .flagsE        (flagsE),
    .memRwD        (execD.memRw),
    .pcSrcE        (pcSrcE),
    .branchSignedE (branchSignedE),
    .memReadE      (memReadE),
    .storeStallD   (storeStallD),
    .memE          (memE)
  );

  ////////////////////////////// Memory and Writeback

  stageReg #(.payloadT(memCtrlT)) i_regM (
    .clk(clk), .rstN(rstN), .ctl(ctlM),
    .d(memE), .q(memM)
  );

  assign wbM = '{regWrite: memM.regWrite, resultSrc: memM.resultSrc};

  stageReg #(.payloadT(wbCtrlT)) i_regW (
    .clk(clk), .rstN(rstN), .ctl(ctlW),
    .d(wbM), .q(wbW)
  );

endmodule

/* source/controllerPkg.sv */
//////////////////////////////
// Types shared by the controller modules and the testbench
// Opcode and selector enums plus the control payload of each stage
// Import with controllerPkg::* in a module body
//////////////////////////////

`include "controller_params.svh"

package controllerPkg;

  ////////////////////////////// Encodings

  typedef enum logic [6:0] {
    opLoad    = 7'b0000011,      // lb lh lw lbu lhu
    opMiscMem = 7'b0001111,      // fence, fence.i
    opOpImm   = 7'b0010011,      // I-type ALU
    opAuipc   = 7'b0010111,
    opStore   = 7'b0100011,      // sb sh sw
    opOp      = 7'b0110011,      // R-type ALU
    opLui     = 7'b0110111,
    opBranch  = 7'b1100011,
    opJalr    = 7'b1100111,
    opJal     = 7'b1101111,
    opSystem  = 7'b1110011       // CSR and privileged
  } opcodeT;

  typedef enum logic [2:0] {
    immI = 3'd0,
    immS = 3'd1,
    immB = 3'd2,
    immJ = 3'd3,
    immU = 3'd4
  } immSrcT;

  typedef enum logic [2:0] {
    resAlu  = 3'd0,              // ALU or address result
    resLoad = 3'd1,              // Load data
    resCsr  = 3'd2               // CSR read data
  } resultSrcT;

  typedef struct packed {
    logic read;                  // Bit 1
    logic write;                 // Bit 0
  } memRwT;

  typedef struct packed {
    logic stall;                 // Hold stage
    logic flush;                 // Clear stage on next edge
  } stageCtlT;

  ////////////////////////////// Stage payloads

  typedef struct packed {
    immSrcT immSrc;
    logic   jump;
    logic   branch;
    logic   illegal;             // No legal decode
    logic   storeStall;          // Store in Execute blocks Decode
  } decodeOutT;

  typedef struct packed {
    logic [`FUNCT3_W-1:0] aluSel;    // ALU operation
    logic                 regWrite;
    resultSrcT            resultSrc;
    memRwT                memRw;
    logic                 jump;
    logic                 branch;
    logic                 aluSrcA;   // PC as operand A
    logic                 aluSrcB;   // Immediate as operand B
    logic                 aluResultSrc;
    logic                 csrRead;
    logic                 csrWrite;
    logic                 privileged;
    logic [`FUNCT3_W-1:0] funct3;
    logic                 subArith;  // sub, sra, slt, sltu
    logic                 invalidateICache;
    logic                 flushDCache;
    logic                 fence;
    logic                 instrValid;
  } execCtrlT;

  typedef struct packed {
    logic                 regWrite;
    resultSrcT            resultSrc;
    memRwT                memRw;
    logic                 csrRead;
    logic                 csrWrite;
    logic                 privileged;
    logic [`FUNCT3_W-1:0] funct3;
    logic                 invalidateICache;
    logic                 flushDCache;
    logic                 csrWriteFence; // Flush younger stages
    logic                 instrValid;
  } memCtrlT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
  } wbCtrlT;

endpackage

/* source/controller_params.svh */
//////////////////////////////
// Build-time switches and field widths for the RV32I pipeline controller
// Include in any file that needs a width or a feature switch
// Switches are 1-bit literals
//////////////////////////////

`ifndef CONTROLLER_PARAMS_SVH
`define CONTROLLER_PARAMS_SVH

// Field widths
`define INSTR_W  32              // Instruction word
`define FUNCT3_W 3               // funct3 field

// Feature switches
`define ZICSR_EN    1'b1         // CSR and privileged instructions legal
`define ZIFENCEI_EN 1'b1         // fence.i acts, otherwise fence is a nop
`define ICACHE_EN   1'b1         // fence.i invalidates I$ and flushes D$
`define DCACHE_EN   1'b1         // Store after store also stalls

`endif

/* source/executeCtrl.sv */
//////////////////////////////
// Execute-stage control logic
// Resolves branches from the comparator flags, derives Execute controls,
// builds the Memory payload and raises the store hazard stall
//////////////////////////////

`timescale 1ns/100ps

`include "controller_params.svh"

module executeCtrl (
  input  controllerPkg::execCtrlT execE,
  input  logic [1:0]              flagsE,        // {eq, lt}
  input  controllerPkg::memRwT    memRwD,        // Access of the instruction in Decode
  output logic                    pcSrcE,        // Redirect fetch
  output logic                    branchSignedE, // Signed compare
  output logic                    memReadE,
  output logic                    storeStallD,
  output controllerPkg::memCtrlT  memE
);

  logic eqE, ltE;
  logic branchFlagE;                             // Selected flag
  logic takenE;

  ////////////////////////////// Branch resolution

  assign {eqE, ltE}  = flagsE;
  assign branchFlagE = execE.funct3[2] ? ltE : eqE; // blt/bge family uses lt
  assign takenE      = branchFlagE ^ execE.funct3[0]; // bne, bge, bgeu invert
  assign pcSrcE      = execE.jump | (execE.branch & takenE);

  // bltu and bgeu compare unsigned
  assign branchSignedE = execE.branch & (execE.funct3[2:1] != 2'b11);

  ////////////////////////////// Execute controls

  assign memReadE = execE.memRw.read;

  // Memory cannot read right after a write, nor write again with a D$
  assign storeStallD = execE.memRw.write &
                       (memRwD.read | (memRwD.write & `DCACHE_EN));

  ////////////////////////////// Memory payload

  assign memE = '{regWrite:         execE.regWrite,
                  resultSrc:        execE.resultSrc,
                  memRw:            execE.memRw,
                  csrRead:          execE.csrRead,
                  csrWrite:         execE.csrWrite,
                  privileged:       execE.privileged,
                  funct3:           execE.funct3,
                  invalidateICache: execE.invalidateICache,
                  flushDCache:      execE.flushDCache,
                  csrWriteFence:    execE.csrWrite | execE.fence, // Flush younger work
                  instrValid:       execE.instrValid};

endmodule

/* source/instrDecoder.sv */
//////////////////////////////
// Decode-stage control for RV32I with exact funct legality checks
// Fully combinational from the instruction in Decode
// Drives the Execute payload and the Decode-only outputs
//////////////////////////////

`timescale 1ns/100ps

`include "controller_params.svh"

module instrDecoder (
  input  logic [`INSTR_W-1:0]      instrD,
  output controllerPkg::execCtrlT  execD,
  output controllerPkg::decodeOutT decodeD
);
  import controllerPkg::*;

  opcodeT               opD;              // Major opcode
  logic [`FUNCT3_W-1:0] funct3D;
  logic [6:0]           funct7D;
  logic [4:0]           rs1D;             // rs1 or CSR uimm
  logic                 funct7ZeroD, funct7b5D;
  logic                 shiftOkD, opOkD, loadOkD, storeOkD, branchOkD, jalrOkD;
  execCtrlT             baseD;            // Main decoder word
  immSrcT               immSrcD;
  logic                 aluOpD;           // ALU op uses funct3
  logic                 legalD;
  logic                 subD, sraD, sltD, sltuD;
  logic                 csrZeroSrcD;      // Set/clear with zero source
  logic                 fenceID;          // fence.i

  // Field extraction
  assign opD     = opcodeT'(instrD[6:0]);
  assign funct3D = instrD[14:12];
  assign funct7D = instrD[31:25];
  assign rs1D    = instrD[19:15];

  ////////////////////////////// Funct legality

  assign funct7ZeroD = (funct7D == 7'b0000000);
  assign funct7b5D   = (funct7D == 7'b0100000);   // srai, sub, sra

  assign shiftOkD  = ((funct3D == 3'b001) & funct7ZeroD) |
                     ((funct3D == 3'b101) & (funct7ZeroD | funct7b5D)) |
                     ((funct3D != 3'b001) & (funct3D != 3'b101)); // Non-shifts take any imm
  assign opOkD     = funct7ZeroD | (funct7b5D & ((funct3D == 3'b000) | (funct3D == 3'b101)));
  assign loadOkD   = funct3D inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
  assign storeOkD  = funct3D inside {3'b000, 3'b001, 3'b010};
  assign branchOkD = (funct3D[2:1] != 2'b01);     // No 010, 011
  assign jalrOkD   = (funct3D == 3'b000);

  ////////////////////////////// Main decoder

  always_comb begin : mainDecode
    baseD   = '0;
    immSrcD = immI;
    aluOpD  = 1'b0;
    legalD  = 1'b0;
    case (opD)
      opLoad: begin
        legalD              = loadOkD;
        baseD.regWrite      = 1'b1;
        baseD.aluSrcB       = 1'b1;
        baseD.memRw.read    = 1'b1;
        baseD.resultSrc     = resLoad;
      end
      opStore: begin
        legalD              = storeOkD;
        immSrcD             = immS;
        baseD.aluSrcB       = 1'b1;
        baseD.memRw.write   = 1'b1;
      end
      opOpImm: begin
        legalD              = shiftOkD;
        baseD.regWrite      = 1'b1;
        baseD.aluSrcB       = 1'b1;
        aluOpD              = 1'b1;
      end
      opOp: begin
        legalD              = opOkD;
        baseD.regWrite      = 1'b1;
        aluOpD              = 1'b1;
      end
      opAuipc: begin
        legalD              = 1'b1;
        baseD.regWrite      = 1'b1;
        immSrcD             = immU;
        baseD.aluSrcA       = 1'b1;         // PC + imm
        baseD.aluSrcB       = 1'b1;
      end
      opLui: begin
        legalD              = 1'b1;
        baseD.regWrite      = 1'b1;
        immSrcD             = immU;
        baseD.aluSrcB       = 1'b1;
        baseD.aluResultSrc  = 1'b1;         // Pass imm through
      end
      opBranch: begin
        legalD              = branchOkD;
        immSrcD             = immB;
        baseD.aluSrcA       = 1'b1;         // Target = PC + imm
        baseD.aluSrcB       = 1'b1;
        baseD.branch        = 1'b1;
      end
      opJalr: begin
        legalD              = jalrOkD;
        baseD.regWrite      = 1'b1;
        baseD.aluSrcB       = 1'b1;
        baseD.jump          = 1'b1;
        baseD.aluResultSrc  = 1'b1;         // Link address
      end
      opJal: begin
        legalD              = 1'b1;
        baseD.regWrite      = 1'b1;
        immSrcD             = immJ;
        baseD.aluSrcA       = 1'b1;
        baseD.aluSrcB       = 1'b1;
        baseD.jump          = 1'b1;
        baseD.aluResultSrc  = 1'b1;
      end
      opMiscMem: begin
        legalD              = 1'b1;         // Plain fence is a nop
        baseD.fence         = `ZIFENCEI_EN;
      end
      opSystem: begin
        legalD              = `ZICSR_EN;
        if (funct3D == 3'b000) begin
          baseD.privileged  = 1'b1;         // ecall, mret etc decoded later
        end else begin
          baseD.csrRead     = 1'b1;
          baseD.resultSrc   = resCsr;
        end
      end
      default: legalD = 1'b0;
    endcase
    // Illegal encodings carry no controls
    if (!legalD) begin
      baseD   = '0;
      immSrcD = immI;
      aluOpD  = 1'b0;
    end
  end

  ////////////////////////////// ALU, CSR and fence detail

  assign subD  = (funct3D == 3'b000) & funct7D[5] & instrD[5]; // Opcode bit 5 splits sub from addi
  assign sraD  = (funct3D == 3'b101) & funct7D[5];
  assign sltD  = (funct3D == 3'b010);
  assign sltuD = (funct3D == 3'b011);

  assign csrZeroSrcD = (rs1D == 5'd0);             // Same bits for rs1 and uimm
  assign fenceID     = baseD.fence & (funct3D == 3'b001) & `ICACHE_EN;

  always_comb begin : execBuild
    execD                  = baseD;
    execD.aluSel           = aluOpD ? funct3D : 3'b000; // Add for address generation
    execD.csrWrite         = baseD.csrRead & ~(csrZeroSrcD & funct3D[1]); // csrrs/csrrc x0
    execD.funct3           = funct3D;
    execD.subArith         = aluOpD & (subD | sraD | sltD | sltuD);
    execD.invalidateICache = fenceID;
    execD.flushDCache      = fenceID;
    execD.instrValid       = 1'b1;
  end

  assign decodeD = '{immSrc:     immSrcD,
                     jump:       baseD.jump,
                     branch:     baseD.branch,
                     illegal:    ~legalD,
                     storeStall: 1'b0};   // Filled in by the execute logic
endmodule

/* source/stageReg.sv */
//////////////////////////////
// Pipeline control register with stall enable and flush clear
// One instance per stage, payload chosen by type parameter
//////////////////////////////

`timescale 1ns/100ps

module stageReg #(
  parameter type payloadT = logic        // Stage control payload
) (
  input  logic                    clk,
  input  logic                    rstN,
  input  controllerPkg::stageCtlT ctl,   // Stall and flush for this stage
  input  payloadT                 d,
  output payloadT                 q
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;                           // Empty stage after reset
    end else if (!ctl.stall) begin       // Stall wins over flush
      if (ctl.flush) begin
        q <= '0;                         // Bubble
      end else begin
        q <= d;
      end
    end
  end

endmodule
